//--- tb.f
nes_input_pkg.sv
mem_bridge_pkg.sv
rv_bridge_fsm.sv
autofire_timer.sv
joypad_shifter.sv
reset_sequencer.sv
nes_glue_top.sv
tb_nes_glue.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the NES glue testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_nes_glue -f tb.f -o sim_nes_glue
out=$(./obj_dir/sim_nes_glue)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

//--- tb_nes_glue.sv
////////////////////
// testbench for the NES glue top level
// clock, reset, 16-bit memory model, directed tests, summary
////////////////////

module tb_nes_glue
    import nes_input_pkg::*;
    import mem_bridge_pkg::*;
;

    localparam int CYCLE_LIMIT = 3000;   // all tests together take well under 1000
    localparam int MEM_DEPTH = 1024;

    logic                  clk;
    logic                  sys_resetn;
    logic                  i_rv_valid;
    rv_req_t               i_rv_req;
    logic                  o_rv_ready;
    logic [RV_DATA_W-1:0]  o_rv_rdata;
    logic                  i_mem_ack;
    logic [MEM_WORD_W-1:0] i_mem_dout;
    logic                  o_mem_req;
    mem_cmd_t              o_mem_cmd;
    snes_buttons_t         i_joy1_btns;
    snes_buttons_t         i_joy2_btns;
    logic                  i_joypad_strobe;
    logic [1:0]            i_joypad_clock;
    logic [1:0]            o_joypad_data;
    logic                  i_loading;
    logic                  o_nes_reset;
    logic                  o_clkref;

    logic [MEM_WORD_W-1:0] mem [MEM_DEPTH];
    integer seed = 32'h71f1_68d5;
    int mem_accesses = 0;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;

    nes_glue_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    end

    ////////////////////
    // memory model
    ////////////////////

    task automatic serve_access();
        logic [9:0] idx;
        idx = o_mem_cmd.addr[9:0];
        if (o_mem_cmd.we) begin
            if (o_mem_cmd.ds[1]) mem[idx][15:8] = o_mem_cmd.din[15:8];
            if (o_mem_cmd.ds[0]) mem[idx][7:0] = o_mem_cmd.din[7:0];
        end
        i_mem_dout = mem[idx];   // held until the next access
        mem_accesses++;
    endtask

    initial begin : mem_model
        int delay;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[10'(i)] = 16'(i * 40503) ^ 16'h5a5a;
        end
        forever begin
            @(negedge clk);
            if (o_mem_req != i_mem_ack) begin
                delay = 1 + ($random(seed) & 3);   // 1 to 4 cycles
                repeat (delay - 1) @(negedge clk);
                serve_access();
                i_mem_ack = o_mem_req;
            end
        end
    end

    ////////////////////
    // compare and report
    ////////////////////

    task automatic check_word(input string name, input logic [RV_DATA_W-1:0] exp,
                              input logic [RV_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
            fail_count++;
        end
    endtask

    ////////////////////
    // bus and pad helpers
    ////////////////////

    task automatic rv_access(input logic [RV_ADDR_W-1:0] addr,
                             input logic [RV_DATA_W-1:0] wdata,
                             input logic [RV_STRB_W-1:0] wstrb,
                             output logic [RV_DATA_W-1:0] rdata);
        @(negedge clk);
        i_rv_req.addr = addr;
        i_rv_req.wdata = wdata;
        i_rv_req.wstrb = wstrb;   // zero strobes make a read
        i_rv_valid = 1'b1;
        @(negedge clk);
        while (!o_rv_ready) @(negedge clk);
        rdata = o_rv_rdata;
        i_rv_valid = 1'b0;
        @(negedge clk);
        check_bit("o_rv_ready", 1'b0, o_rv_ready);   // one-cycle pulse
    endtask

    task automatic pulse_pad_clock(input logic port);
        i_joypad_clock[port] = 1'b1;
        @(negedge clk);
        i_joypad_clock[port] = 1'b0;
        @(negedge clk);   // shift lands on the next rising edge
    endtask

    task automatic read_pad(input logic port, input nes_pad_t exp, input string name);
        nes_pad_t rest;
        rest = exp;
        for (int i = 0; i < JOY_BITS + 3; i++) begin
            // lowest bit first, past the byte the pad reads 1
            check_bit(name, (i < JOY_BITS) ? rest[0] : 1'b1, o_joypad_data[port]);
            rest = rest >> 1;
            pulse_pad_clock(port);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_full_word();
        int errs;
        int n;
        logic [RV_DATA_W-1:0] rd;
        errs = error_count;
        n = mem_accesses;
        rv_access(23'h000100, 32'hdead_beef, 4'hf, rd);
        check_count("write accesses", n + 2, mem_accesses);
        // byte address 0x100 maps to words 0x80 and 0x81
        check_word("mem[0x81:0x80]", 32'hdead_beef, {mem[10'h081], mem[10'h080]});
        n = mem_accesses;
        rv_access(23'h000100, 32'h0, 4'h0, rd);
        check_count("read accesses", n + 2, mem_accesses);
        check_word("o_rv_rdata", 32'hdead_beef, rd);
        report_test("full word write and read", errs);
    endtask

    task automatic test_half_writes();
        int errs;
        int n;
        logic [RV_DATA_W-1:0] rd;
        errs = error_count;
        rv_access(23'h000200, 32'h1122_3344, 4'hf, rd);
        n = mem_accesses;
        rv_access(23'h000200, 32'haabb_ccdd, 4'b1100, rd);
        check_count("upper write accesses", n + 1, mem_accesses);
        rv_access(23'h000200, 32'h0, 4'h0, rd);
        check_word("o_rv_rdata", 32'haabb_3344, rd);
        n = mem_accesses;
        rv_access(23'h000200, 32'h5566_7788, 4'b0011, rd);
        check_count("lower write accesses", n + 1, mem_accesses);
        rv_access(23'h000200, 32'h0, 4'h0, rd);
        check_word("o_rv_rdata", 32'haabb_7788, rd);
        report_test("half word writes", errs);
    endtask

    task automatic test_joypads();
        int errs;
        logic [11:0] pat1;
        logic [11:0] pat2;
        errs = error_count;
        pat1 = 12'h0a5;   // no turbo sources, no Select+Up
        pat2 = 12'h05c;
        @(negedge clk);
        i_joy1_btns = snes_buttons_t'(pat1);
        i_joy2_btns = snes_buttons_t'(pat2);
        i_joypad_strobe = 1'b1;
        @(negedge clk);
        i_joypad_strobe = 1'b0;
        @(negedge clk);
        read_pad(1'b0, pat1[7:0], "o_joypad_data[0]");
        check_bit("o_joypad_data[1]", pat2[0], o_joypad_data[1]);   // untouched by port 1
        read_pad(1'b1, pat2[7:0], "o_joypad_data[1]");
        i_joy1_btns = '0;
        i_joy2_btns = '0;
        report_test("joypad shift out", errs);
    endtask

    task automatic test_autofire();
        int errs;
        int ones;
        logic level;
        errs = error_count;
        @(negedge clk);
        i_joy1_btns = snes_buttons_t'(12'h100);   // turbo A held, plain A released
        i_joypad_strobe = 1'b1;
        for (int k = 0; k < 4 * AUTOFIRE_HALF; k++) begin
            @(negedge clk);
            level = ((k / AUTOFIRE_HALF) % 2) == 0;   // fires first, then alternates
            check_bit("o_joypad_data[0]", level, o_joypad_data[0]);
        end
        i_joy1_btns = '0;
        ones = 0;
        @(negedge clk);
        repeat (2 * AUTOFIRE_HALF) begin
            @(negedge clk);
            if (o_joypad_data[0]) ones++;
        end
        check_count("released ones", 0, ones);
        i_joypad_strobe = 1'b0;
        report_test("autofire on A", errs);
    endtask

    task automatic test_loading();
        int errs;
        errs = error_count;
        check_bit("o_nes_reset", 1'b1, o_nes_reset);   // held since reset
        i_loading = 1'b1;
        repeat (3) @(negedge clk);
        i_loading = 1'b0;
        @(negedge clk);
        check_bit("o_nes_reset", 1'b0, o_nes_reset);
        check_bit("o_clkref", 1'b1, o_clkref);
        @(negedge clk);
        check_bit("o_clkref", 1'b0, o_clkref);
        i_loading = 1'b1;
        @(negedge clk);
        check_bit("o_nes_reset", 1'b1, o_nes_reset);
        i_loading = 1'b0;
        @(negedge clk);
        check_bit("o_nes_reset", 1'b0, o_nes_reset);
        check_bit("o_clkref", 1'b1, o_clkref);
        report_test("loading edges", errs);
    endtask

    task automatic test_reset_combo();
        int errs;
        errs = error_count;
        i_joy1_btns = snes_buttons_t'(12'h014);   // Select + Up
        repeat (COMBO_HOLD - 1) begin
            @(negedge clk);
            check_bit("o_nes_reset", 1'b0, o_nes_reset);
        end
        i_joy1_btns = '0;
        repeat (4) begin
            @(negedge clk);
            check_bit("o_nes_reset", 1'b0, o_nes_reset);
        end
        // the release restarts the count
        i_joy1_btns = snes_buttons_t'(12'h014);
        repeat (COMBO_HOLD - 1) begin
            @(negedge clk);
            check_bit("o_nes_reset", 1'b0, o_nes_reset);
        end
        repeat (5) @(negedge clk);
        check_bit("o_nes_reset", 1'b1, o_nes_reset);
        i_joy1_btns = '0;
        repeat (8) begin
            @(negedge clk);
            check_bit("o_nes_reset", 1'b1, o_nes_reset);
        end
        i_loading = 1'b1;
        repeat (2) @(negedge clk);
        i_loading = 1'b0;
        @(negedge clk);
        check_bit("o_nes_reset", 1'b0, o_nes_reset);
        report_test("Select+Up reset", errs);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        sys_resetn = 1'b0;
        i_rv_valid = 1'b0;
        i_rv_req = '0;
        i_mem_ack = 1'b0;
        i_mem_dout = '0;
        i_joy1_btns = '0;
        i_joy2_btns = '0;
        i_joypad_strobe = 1'b0;
        i_joypad_clock = 2'b00;
        i_loading = 1'b0;
        repeat (5) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);

        test_loading();
        test_full_word();
        test_half_writes();
        test_joypads();
        test_autofire();
        test_reset_combo();

        $display("tests: %0d ok, %0d failed, %0d errors", pass_count, fail_count, error_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- nes_glue_top.sv
////////////////////
// NES glue top level
// memory bridge, autofire, joypads, console reset
////////////////////

module nes_glue_top
    import nes_input_pkg::*;
    import mem_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  sys_resetn,

    // soft-core bus
    input  logic                  i_rv_valid,
    input  rv_req_t               i_rv_req,
    output logic                  o_rv_ready,
    output logic [RV_DATA_W-1:0]  o_rv_rdata,

    // 16-bit memory port
    input  logic                  i_mem_ack,
    input  logic [MEM_WORD_W-1:0] i_mem_dout,
    output logic                  o_mem_req,
    output mem_cmd_t              o_mem_cmd,

    // joypads
    input  snes_buttons_t         i_joy1_btns,
    input  snes_buttons_t         i_joy2_btns,
    input  logic                  i_joypad_strobe,
    input  logic [1:0]            i_joypad_clock,
    output logic [1:0]            o_joypad_data,

    // console control
    input  logic                  i_loading,
    output logic                  o_nes_reset,
    output logic                  o_clkref
);

    logic turbo_a1, turbo_b1;
    logic turbo_a2, turbo_b2;

    rv_bridge_fsm u_bridge (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_rv_valid (i_rv_valid),
        .i_rv_req   (i_rv_req),
        .i_mem_ack  (i_mem_ack),
        .i_mem_dout (i_mem_dout),
        .o_rv_ready (o_rv_ready),
        .o_rv_rdata (o_rv_rdata),
        .o_mem_req  (o_mem_req),
        .o_mem_cmd  (o_mem_cmd)
    );

    ////////////////////
    // autofire, A from SNES A and B from SNES X
    ////////////////////

    autofire_timer u_af_a1 (.clk(clk), .sys_resetn(sys_resetn), .i_btn(i_joy1_btns.a),
                            .o_turbo(turbo_a1));
    autofire_timer u_af_b1 (.clk(clk), .sys_resetn(sys_resetn), .i_btn(i_joy1_btns.x),
                            .o_turbo(turbo_b1));
    autofire_timer u_af_a2 (.clk(clk), .sys_resetn(sys_resetn), .i_btn(i_joy2_btns.a),
                            .o_turbo(turbo_a2));
    autofire_timer u_af_b2 (.clk(clk), .sys_resetn(sys_resetn), .i_btn(i_joy2_btns.x),
                            .o_turbo(turbo_b2));

    joypad_shifter u_pad1 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_btns      (i_joy1_btns),
        .i_turbo_a   (turbo_a1),
        .i_turbo_b   (turbo_b1),
        .i_strobe    (i_joypad_strobe),
        .i_pad_clock (i_joypad_clock[0]),
        .o_data      (o_joypad_data[0])
    );

    joypad_shifter u_pad2 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_btns      (i_joy2_btns),
        .i_turbo_a   (turbo_a2),
        .i_turbo_b   (turbo_b2),
        .i_strobe    (i_joypad_strobe),
        .i_pad_clock (i_joypad_clock[1]),
        .o_data      (o_joypad_data[1])
    );

    // reset combo watches port 1 only
    reset_sequencer u_reset (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_loading   (i_loading),
        .i_btns      (i_joy1_btns),
        .o_nes_reset (o_nes_reset),
        .o_clkref    (o_clkref)
    );

endmodule

//--- reset_sequencer.sv
////////////////////
// console core reset and memory phase reference
////////////////////

module reset_sequencer
    import nes_input_pkg::*;
(
    input  logic          clk,
    input  logic          sys_resetn,
    input  logic          i_loading,
    input  snes_buttons_t i_btns,
    output logic          o_nes_reset,
    output logic          o_clkref
);

    logic                   loading_q;
    logic [COMBO_CNT_W-1:0] combo_cnt;
    logic                   nes_reset;
    logic                   clkref;

    logic loading_rise;
    logic loading_fall;
    logic combo_held;
    logic combo_done;

    assign loading_rise = i_loading & ~loading_q;
    assign loading_fall = ~i_loading & loading_q;
    assign combo_held = i_btns.select & i_btns.up;
    assign combo_done = (combo_cnt == COMBO_CNT_W'(COMBO_HOLD));

    // consecutive Select+Up cycles
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            combo_cnt <= '0;
        end else if (!combo_held) begin
            combo_cnt <= '0;
        end else if (!combo_done) begin
            combo_cnt <= combo_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_q <= 1'b0;
            nes_reset <= 1'b1;   // core held until a ROM is loaded
            clkref <= 1'b0;
        end else begin
            loading_q <= i_loading;
            clkref <= ~clkref;
            if (loading_fall) begin
                nes_reset <= 1'b0;
                clkref <= 1'b1;      // realign phase to the released core
            end else if (loading_rise || combo_done) begin
                nes_reset <= 1'b1;
            end
        end
    end

    assign o_nes_reset = nes_reset;
    assign o_clkref = clkref;

endmodule

//--- joypad_shifter.sv
////////////////////
// NES joypad serializer for one port
// latch on strobe, shift on falling pad clock
////////////////////

module joypad_shifter
    import nes_input_pkg::*;
(
    input  logic          clk,
    input  logic          sys_resetn,
    input  snes_buttons_t i_btns,
    input  logic          i_turbo_a,
    input  logic          i_turbo_b,
    input  logic          i_strobe,
    input  logic          i_pad_clock,
    output logic          o_data
);

    nes_pad_t pad_bits;
    nes_pad_t load_bits;
    logic     pad_clock_q;
    logic     clock_fall;

    // NES order: right left down up start select B A
    assign load_bits = {
        i_btns.rt,
        i_btns.lt,
        i_btns.dn,
        i_btns.up,
        i_btns.start,
        i_btns.select,
        i_btns.y | i_turbo_b,
        i_btns.b | i_turbo_a
    };

    assign clock_fall = pad_clock_q & ~i_pad_clock;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pad_bits <= '1;
            pad_clock_q <= 1'b0;
        end else begin
            pad_clock_q <= i_pad_clock;
            if (i_strobe) begin
                pad_bits <= load_bits;    // reload every cycle while high
            end else if (clock_fall) begin
                pad_bits <= {1'b1, pad_bits[JOY_BITS-1:1]};   // empty slots read as 1
            end
        end
    end

    assign o_data = pad_bits[0];

endmodule

//--- autofire_timer.sv
////////////////////
// turbo level generator for one button
////////////////////

module autofire_timer
    import nes_input_pkg::*;
(
    input  logic clk,
    input  logic sys_resetn,
    input  logic i_btn,
    output logic o_turbo
);

    logic [AF_CNT_W-1:0] cnt;
    logic                level;   // starts high so the first press fires at once

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            cnt <= '0;
            level <= 1'b1;
        end else if (!i_btn) begin
            cnt <= '0;            // released, restart the pattern
            level <= 1'b1;
        end else if (cnt == AF_CNT_W'(AUTOFIRE_HALF - 1)) begin
            cnt <= '0;
            level <= ~level;      // end of a half-period
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_turbo = i_btn & level;

endmodule

//--- rv_bridge_fsm.sv
////////////////////
// 32-bit soft-core bus to 16-bit toggle memory port
// splits each access into one or two word accesses
////////////////////

module rv_bridge_fsm
    import mem_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_rv_valid,
    input  rv_req_t               i_rv_req,
    input  logic                  i_mem_ack,
    input  logic [MEM_WORD_W-1:0] i_mem_dout,
    output logic                  o_rv_ready,
    output logic [RV_DATA_W-1:0]  o_rv_rdata,
    output logic                  o_mem_req,
    output mem_cmd_t              o_mem_cmd
);

    bridge_state_e state, state_nxt;

    logic                  valid_q;
    logic                  pending;     // valid rise seen while busy
    logic                  mem_req;
    logic                  rv_ready;
    logic                  word_sel, word_nxt;
    logic [1:0]            ds, ds_nxt;
    logic [MEM_WORD_W-1:0] rd_lo;

    logic valid_rise;
    logic is_write;
    logic acked;
    logic toggle;
    logic ready_nxt;
    logic take_req;
    logic lo_capture;
    logic lo_strb_zero;
    logic hi_strb_zero;

    assign valid_rise = i_rv_valid & ~valid_q;
    assign is_write = |i_rv_req.wstrb;
    assign acked = (i_mem_ack == mem_req);   // memory caught up with our toggle
    assign lo_strb_zero = (i_rv_req.wstrb[1:0] == 2'b00);
    assign hi_strb_zero = (i_rv_req.wstrb[3:2] == 2'b00);

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        word_nxt = word_sel;
        ds_nxt = ds;
        toggle = 1'b0;
        ready_nxt = 1'b0;
        take_req = 1'b0;
        lo_capture = 1'b0;

        case (state)
            IDLE_REQ0: begin
                if (valid_rise || pending) begin
                    take_req = 1'b1;
                    toggle = 1'b1;
                    if (is_write && lo_strb_zero) begin
                        // upper half only, skip the lower word
                        word_nxt = 1'b1;
                        ds_nxt = i_rv_req.wstrb[3:2];
                        state_nxt = WAIT1;
                    end else begin
                        word_nxt = 1'b0;
                        ds_nxt = is_write ? i_rv_req.wstrb[1:0] : 2'b11;
                        state_nxt = WAIT0_REQ1;
                    end
                end
            end

            WAIT0_REQ1: begin
                if (acked) begin
                    if (!is_write) begin
                        state_nxt = DATA0;
                    end else if (hi_strb_zero) begin
                        ready_nxt = 1'b1;       // lower half only, done
                        state_nxt = IDLE_REQ0;
                    end else begin
                        toggle = 1'b1;
                        word_nxt = 1'b1;
                        ds_nxt = i_rv_req.wstrb[3:2];
                        state_nxt = WAIT1;
                    end
                end
            end

            DATA0: begin
                // lower word still on the port, grab it before asking for the upper
                lo_capture = 1'b1;
                toggle = 1'b1;
                word_nxt = 1'b1;
                ds_nxt = 2'b11;
                state_nxt = WAIT1;
            end

            WAIT1: begin
                if (acked) begin
                    if (is_write) begin
                        ready_nxt = 1'b1;
                        state_nxt = IDLE_REQ0;
                    end else begin
                        state_nxt = DATA1;
                    end
                end
            end

            DATA1: begin
                ready_nxt = 1'b1;
                state_nxt = IDLE_REQ0;
            end

            default: state_nxt = IDLE_REQ0;
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state <= IDLE_REQ0;
            valid_q <= 1'b0;
            pending <= 1'b0;
            mem_req <= 1'b0;
            rv_ready <= 1'b0;
        end else begin
            state <= state_nxt;
            valid_q <= i_rv_valid;
            pending <= take_req ? 1'b0 : (pending | valid_rise);
            mem_req <= mem_req ^ toggle;
            rv_ready <= ready_nxt;
        end
    end

    // command fields and read data
    always_ff @(posedge clk) begin
        word_sel <= word_nxt;
        ds <= ds_nxt;
        if (lo_capture) begin
            rd_lo <= i_mem_dout;
        end
    end

    assign o_mem_req = mem_req;
    assign o_rv_ready = rv_ready;
    assign o_rv_rdata = {i_mem_dout, rd_lo};   // upper word above lower

    assign o_mem_cmd.addr = {i_rv_req.addr[MEM_ADDR_W:2], word_sel};
    assign o_mem_cmd.din = word_sel ? i_rv_req.wdata[RV_DATA_W-1:MEM_WORD_W]
                                    : i_rv_req.wdata[MEM_WORD_W-1:0];
    assign o_mem_cmd.ds = ds;
    assign o_mem_cmd.we = is_write;

endmodule

//--- mem_bridge_pkg.sv
////////////////////
// soft-core bus and 16-bit memory port types
// bridge state encoding
////////////////////

package mem_bridge_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int RV_ADDR_W = 23;             // soft-core byte address
    localparam int RV_DATA_W = 32;
    localparam int RV_STRB_W = RV_DATA_W / 8;  // one strobe per byte
    localparam int MEM_WORD_W = 16;
    localparam int MEM_ADDR_W = 20;            // word address incl. word select

    ////////////////////
    // bus payloads
    ////////////////////

    // soft-core access, held stable until ready
    // wstrb of zero means a read
    typedef struct packed {
        logic [RV_ADDR_W-1:0] addr;
        logic [RV_DATA_W-1:0] wdata;
        logic [RV_STRB_W-1:0] wstrb;
    } rv_req_t;

    // one word access on the memory port
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_WORD_W-1:0] din;
        logic [1:0]            ds;    // byte selects, bit 1 is the high byte
        logic                  we;
    } mem_cmd_t;

    ////////////////////
    // bridge FSM
    ////////////////////

    typedef enum logic [2:0] {
        IDLE_REQ0,    // wait for a request, issue first word
        WAIT0_REQ1,   // first word in flight
        DATA0,        // read: hold lower word, issue upper word
        WAIT1,        // upper word in flight
        DATA1         // read: upper word on the port
    } bridge_state_e;

endpackage

//--- nes_input_pkg.sv
////////////////////
// button layout for the board pads
// NES joypad byte, autofire and reset-combo constants
////////////////////

package nes_input_pkg;

    ////////////////////
    // button layouts
    ////////////////////

    // decoded board buttons, SNES layout, top bit first
    // lower eight are the NES buttons
    typedef struct packed {
        logic r;
        logic l;
        logic x;      // turbo B source
        logic a;      // turbo A source
        logic rt;
        logic lt;
        logic dn;
        logic up;
        logic start;
        logic select;
        logic y;      // NES B position
        logic b;      // NES A position
    } snes_buttons_t;

    // serial joypad length
    localparam int JOY_BITS = 8;

    // byte as the console shifts it, bit 0 goes out first
    typedef logic [JOY_BITS-1:0] nes_pad_t;

    ////////////////////
    // timing constants
    ////////////////////

    // turbo half-period in clocks
    localparam int AUTOFIRE_HALF = 8;
    localparam int AF_CNT_W = (AUTOFIRE_HALF > 1) ? $clog2(AUTOFIRE_HALF) : 1;

    // Select+Up must be held this long before the core is reset
    localparam int COMBO_HOLD = 16;
    localparam int COMBO_CNT_W = $clog2(COMBO_HOLD + 1);   // counter saturates at COMBO_HOLD

endpackage
